/* build.f */
design/clk_cfg_pkg.sv
design/wb_pkg.sv
design/clk_infra_regs.sv
design/lock_monitor.sv
design/rst_sequencer.sv
design/clk_phase_gen.sv
design/clk_infra_top.sv
dv/clk_infra_checker.sv
dv/tb_top.sv

/* dv/tb_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_top;

  typedef struct packed {
    clk_cfg_pkg::div_sel_e div_sel;
    logic                  phase_en;
    logic                  pulse_rst;  // Pulse idelay_rst once ready
    logic [5:0]            period;
    logic [7:0]            relock;
  } stim_t;

  localparam int NUM_TESTS = 7;

  logic                  sys_clk;
  logic                  arst_n;
  wb_pkg::wb_req_t       wb_req;
  wb_pkg::wb_rsp_t       wb_rsp;
  logic                  idelay_rst;
  logic                  op_power_on_rst;
  logic                  idelay_rdy;
  logic                  sys_clk_lock;
  wire  [3:0]            phases;
  logic [5:0]            exp_period;
  logic                  exp_phase_en;
  logic [31:0]           rdat;
  logic                  lock_lost;
  clk_cfg_pkg::div_sel_e cur_div;
  stim_t                 stim_tbl [NUM_TESTS];
  string                 names [NUM_TESTS];
  string                 test_name;
  int                    tb_errs;
  int                    chk_errs;
  int                    seed;

  always #20 sys_clk = ~sys_clk;

  clk_infra_top dut (
    .sys_clk         (sys_clk),
    .arst_n          (arst_n),
    .wb_req          (wb_req),
    .wb_rsp          (wb_rsp),
    .idelay_rst      (idelay_rst),
    .op_power_on_rst (op_power_on_rst),
    .idelay_rdy      (idelay_rdy),
    .sys_clk_lock    (sys_clk_lock),
    .ph0             (phases[0]),
    .ph90            (phases[1]),
    .ph180           (phases[2]),
    .ph270           (phases[3])
  );

  clk_infra_checker u_chk (
    .sys_clk         (sys_clk),
    .arst_n          (arst_n),
    .wb_req          (wb_req),
    .wb_rsp          (wb_rsp),
    .idelay_rst      (idelay_rst),
    .op_power_on_rst (op_power_on_rst),
    .idelay_rdy      (idelay_rdy),
    .sys_clk_lock    (sys_clk_lock),
    .phases          (phases),
    .exp_period      (exp_period),
    .exp_phase_en    (exp_phase_en),
    .err_cnt         (chk_errs)
  );

  // Leaves the caller 2 ns after a rising edge
  task automatic step_cycles(input int n);
    repeat (n) begin
      @(posedge sys_clk);
      #2;
    end
  endtask

  task automatic bus_xfer(input logic we, input logic [3:0] adr, input logic [31:0] wdat,
                          output logic [31:0] data);
    int n;
    n    = 0;
    data = '0;
    wb_req = {1'b1, 1'b1, we, adr, wdat};  // cyc, stb, we, adr, dat
    @(negedge sys_clk);
    while (!wb_rsp.ack && n < 20) begin
      n++;
      @(negedge sys_clk);
    end
    if (wb_rsp.ack) begin
      data = wb_rsp.dat;
    end else begin
      $display("Testbench: no ack from the register block at address %0d", adr);
      tb_errs++;
    end
    step_cycles(1);
    wb_req = '0;
    step_cycles(1 + $unsigned($random(seed)) % 4);  // Random idle gap
  endtask

  task automatic read_check(input string what, input logic [3:0] adr, input logic [31:0] exp_v);
    logic [31:0] data;
    bus_xfer(1'b0, adr, 32'h0, data);
    if (data !== exp_v) begin
      $display("ERROR %s: %s expected 0x%0h actual 0x%0h", test_name, what, exp_v, data);
      tb_errs++;
    end
  endtask

  // use_rdy selects idelay_rdy instead of sys_clk_lock
  task automatic wait_level(input string what, input logic use_rdy, input logic level,
                            input int limit);
    int n;
    n = 0;
    @(negedge sys_clk);
    while (((use_rdy ? idelay_rdy : sys_clk_lock) !== level) && n < limit) begin
      n++;
      @(negedge sys_clk);
    end
    if ((use_rdy ? idelay_rdy : sys_clk_lock) !== level) begin
      $display("Testbench: timed out waiting for %s in %s", what, test_name);
      tb_errs++;
    end
    step_cycles(1);
  endtask

  initial begin
    sys_clk      = 1'b0;
    arst_n       = 1'b0;
    wb_req       = '0;
    idelay_rst   = 1'b0;
    exp_period   = 6'd8;
    exp_phase_en = 1'b1;
    lock_lost    = 1'b0;
    tb_errs      = 0;
    seed         = 32'h5680;
    test_name    = "reset";
    cur_div      = clk_cfg_pkg::DIV8;
    names[0]     = "div8_same";
    stim_tbl[0]  = '{clk_cfg_pkg::DIV8,  1'b1, 1'b0, 6'd8,  8'd1};
    names[1]     = "div4";
    stim_tbl[1]  = '{clk_cfg_pkg::DIV4,  1'b1, 1'b0, 6'd4,  8'd2};
    names[2]     = "div16_cal";
    stim_tbl[2]  = '{clk_cfg_pkg::DIV16, 1'b1, 1'b1, 6'd16, 8'd3};
    names[3]     = "div32";
    stim_tbl[3]  = '{clk_cfg_pkg::DIV32, 1'b1, 1'b0, 6'd32, 8'd4};
    names[4]     = "div32_same";
    stim_tbl[4]  = '{clk_cfg_pkg::DIV32, 1'b1, 1'b0, 6'd32, 8'd4};
    names[5]     = "phase_off";
    stim_tbl[5]  = '{clk_cfg_pkg::DIV32, 1'b0, 1'b0, 6'd32, 8'd4};
    names[6]     = "div8_cal";
    stim_tbl[6]  = '{clk_cfg_pkg::DIV8,  1'b1, 1'b1, 6'd8,  8'd5};

    step_cycles(16);
    arst_n = 1'b1;
    wait_level("lock after reset", 1'b0, 1'b1, 200);
    wait_level("calibration after reset", 1'b1, 1'b1, 200);
    read_check("STATUS", wb_pkg::REG_STATUS, 32'h5);
    read_check("CTRL", wb_pkg::REG_CTRL, 32'h5);

    for (int i = 0; i < NUM_TESTS; i++) begin
      test_name    = names[i];
      exp_period   = stim_tbl[i].period;
      exp_phase_en = stim_tbl[i].phase_en;
      bus_xfer(1'b1, wb_pkg::REG_CTRL, {29'd0, stim_tbl[i].phase_en, stim_tbl[i].div_sel}, rdat);
      if (stim_tbl[i].div_sel != cur_div) begin
        wait_level("lock drop", 1'b0, 1'b0, 20);
        wait_level("relock", 1'b0, 1'b1, 200);
        wait_level("calibration", 1'b1, 1'b1, 200);
      end else begin
        lock_lost = 1'b0;
        repeat (8) begin
          @(negedge sys_clk);
          if (!sys_clk_lock) lock_lost = 1'b1;
        end
        step_cycles(1);
        if (lock_lost) begin
          $display("Testbench: lock dropped on an unchanged divide in %s", test_name);
          tb_errs++;
        end
      end
      cur_div = stim_tbl[i].div_sel;
      if (stim_tbl[i].pulse_rst) begin
        idelay_rst = 1'b1;
        step_cycles(2);
        idelay_rst = 1'b0;
        wait_level("calibration after idelay_rst", 1'b1, 1'b1, 200);
      end
      step_cycles(4 * stim_tbl[i].period);  // A few strobe periods for the checker
      read_check("RELOCK", wb_pkg::REG_RELOCK, 32'(stim_tbl[i].relock));
      read_check("STATUS", wb_pkg::REG_STATUS, 32'h5);
      read_check("CTRL", wb_pkg::REG_CTRL, {29'd0, stim_tbl[i].phase_en, stim_tbl[i].div_sel});
    end

    // Read-only status and an unused address
    test_name = "status_ro";
    bus_xfer(1'b1, wb_pkg::REG_STATUS, 32'h0, rdat);
    read_check("STATUS after write", wb_pkg::REG_STATUS, 32'h5);
    read_check("unused address", 4'd3, 32'h0);

    $display("Error counts: testbench %0d, checker %0d", tb_errs, chk_errs);
    if (tb_errs == 0 && chk_errs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* dv/clk_infra_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module clk_infra_checker (
  input  logic            sys_clk,
  input  logic            arst_n,
  input  wb_pkg::wb_req_t wb_req,
  input  wb_pkg::wb_rsp_t wb_rsp,
  input  logic            idelay_rst,
  input  logic            op_power_on_rst,
  input  logic            idelay_rdy,
  input  logic            sys_clk_lock,
  input  logic [3:0]      phases,        // {ph270, ph180, ph90, ph0}
  input  logic [5:0]      exp_period,
  input  logic            exp_phase_en,
  output int              err_cnt
);

  int         period;
  int         since;     // Cycles since the last ph0
  int         por_cnt;
  int         rdy_cnt;
  logic       tracking;
  logic       pe_model;
  logic       prev_lock;
  logic       prev_blk;
  logic       por_arm;
  logic       rdy_arm;
  logic       blk;
  logic [2:0] exp_ph;    // {ph270, ph180, ph90}

  assign blk = op_power_on_rst | idelay_rst;  // Anything that holds off calibration

  initial err_cnt = 0;

  task automatic report_mismatch(input string what, input int exp_v, input int act_v);
    $display("ERROR %s: %s expected %0d actual %0d", tb_top.test_name, what, exp_v, act_v);
    err_cnt++;
  endtask

  task automatic report_fault(input string what);
    $display("Checker at %0t ns: %s", $time, what);
    err_cnt++;
  endtask

  // Sampled mid-cycle away from the clock edge
  always @(negedge sys_clk) begin
    if (!arst_n) begin
      period    = exp_period;
      pe_model  = exp_phase_en;
      tracking  = 1'b0;
      since     = 0;
      prev_lock = 1'b0;
      prev_blk  = 1'b1;
      por_arm   = 1'b0;
      rdy_arm   = 1'b0;
    end else begin
      // A CTRL write takes effect in the ack cycle
      if (wb_rsp.ack && wb_req.we && wb_req.adr == wb_pkg::REG_CTRL) begin
        period   = exp_period;
        pe_model = exp_phase_en;
        tracking = 1'b0;
      end
      if (op_power_on_rst || !pe_model) begin
        tracking = 1'b0;
        if (phases != 4'b0000) report_fault("phase strobe while disabled or in power-on reset");
      end else begin
        if (tracking) since++;
        if (phases[0]) begin
          if (tracking && since != period) report_mismatch("ph0 spacing", period, since);
          tracking = 1'b1;
          since    = 0;
        end else if (tracking) begin
          // Each quadrature strobe must appear at its offset and nowhere else
          exp_ph = {since == 3 * period / 4, since == period / 2, since == period / 4};
          if (phases[3:1] != exp_ph) begin
            report_mismatch($sformatf("quadrature strobes at offset %0d", since),
                            exp_ph, phases[3:1]);
          end
          if (since > period) begin
            report_fault("ph0 strobe missing");
            tracking = 1'b0;
          end
        end
      end

      // Power-on reset follows lock
      if (!sys_clk_lock && !op_power_on_rst) report_fault("power-on reset low while lock is low");
      if (!sys_clk_lock) begin
        por_arm = 1'b0;
      end else if (!prev_lock) begin
        por_arm = 1'b1;
        por_cnt = 0;
      end else if (por_arm) begin
        por_cnt++;
        if (!op_power_on_rst) begin
          if (por_cnt != clk_cfg_pkg::POR_HOLD)
            report_mismatch("POR hold", clk_cfg_pkg::POR_HOLD, por_cnt);
          por_arm = 1'b0;
        end
      end

      // Calibration time once reset and idelay_rst are both gone
      if (blk && idelay_rdy) report_fault("idelay_rdy high during reset or idelay_rst");
      if (blk) begin
        rdy_arm = 1'b0;
      end else if (prev_blk) begin
        rdy_arm = 1'b1;
        rdy_cnt = 0;
      end else if (rdy_arm) begin
        rdy_cnt++;
        if (idelay_rdy) begin
          if (rdy_cnt != clk_cfg_pkg::IDELAY_CYCLES)
            report_mismatch("calibration time", clk_cfg_pkg::IDELAY_CYCLES, rdy_cnt);
          rdy_arm = 1'b0;
        end
      end
      prev_lock = sys_clk_lock;
      prev_blk  = blk;
    end
  end

endmodule

`default_nettype wire

/* design/clk_infra_top.sv */
`timescale 1ns/1ns
`default_nettype none

module clk_infra_top (
  input  logic            sys_clk,
  input  logic            arst_n,
  input  wb_pkg::wb_req_t wb_req,
  output wb_pkg::wb_rsp_t wb_rsp,
  input  logic            idelay_rst,
  output logic            op_power_on_rst,
  output logic            idelay_rdy,
  output logic            sys_clk_lock,
  output logic            ph0,
  output logic            ph90,
  output logic            ph180,
  output logic            ph270
);

  clk_cfg_pkg::div_sel_e    div_sel;
  clk_cfg_pkg::clk_status_t status;
  logic                     phase_en;
  logic [7:0]               relock_cnt;

  assign status = '{
    locked:     sys_clk_lock,
    por_active: op_power_on_rst,
    idelay_rdy: idelay_rdy,
    relock_cnt: relock_cnt
  };

  clk_infra_regs u_regs (
    .sys_clk  (sys_clk),
    .arst_n   (arst_n),
    .wb_req   (wb_req),
    .wb_rsp   (wb_rsp),
    .status   (status),
    .div_sel  (div_sel),
    .phase_en (phase_en)
  );

  // MMCM lock model
  lock_monitor u_lock (
    .sys_clk    (sys_clk),
    .arst_n     (arst_n),
    .div_sel    (div_sel),
    .locked     (sys_clk_lock),
    .relock_cnt (relock_cnt)
  );

  rst_sequencer u_seq (
    .sys_clk    (sys_clk),
    .arst_n     (arst_n),
    .locked     (sys_clk_lock),
    .idelay_rst (idelay_rst),
    .por_active (op_power_on_rst),
    .idelay_rdy (idelay_rdy)
  );

  clk_phase_gen u_phase (
    .sys_clk    (sys_clk),
    .arst_n     (arst_n),
    .div_sel    (div_sel),
    .phase_en   (phase_en),
    .por_active (op_power_on_rst),
    .ph0        (ph0),
    .ph90       (ph90),
    .ph180      (ph180),
    .ph270      (ph270)
  );

endmodule

`default_nettype wire

/* design/clk_phase_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module clk_phase_gen (
  input  logic                  sys_clk,
  input  logic                  arst_n,
  input  clk_cfg_pkg::div_sel_e div_sel,
  input  logic                  phase_en,
  input  logic                  por_active,
  output logic                  ph0,
  output logic                  ph90,
  output logic                  ph180,
  output logic                  ph270
);

  logic [5:0] period;
  logic [4:0] last_cnt;
  logic [4:0] q1;
  logic [4:0] q2;
  logic [4:0] q3;
  logic [4:0] cnt;
  logic [3:0] hit_q;  // {270, 180, 90, 0}
  logic       run;

  assign period   = clk_cfg_pkg::div_period(div_sel);
  assign last_cnt = 5'(period - 6'd1);
  assign q1       = {1'b0, period[5:2]};  // P/4
  assign q2       = period[5:1];          // P/2
  assign q3       = q1 + q2;              // 3P/4
  assign run      = phase_en & ~por_active;

  always_ff @(posedge sys_clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt   <= '0;
      hit_q <= '0;
    end else begin
      if (por_active || cnt >= last_cnt) begin
        cnt <= '0;  // Restart after POR, wrap at P-1
      end else begin
        cnt <= cnt + 5'd1;
      end
      if (por_active) begin
        hit_q <= '0;
      end else begin
        hit_q <= {cnt == q3, cnt == q2, cnt == q1, cnt == 5'd0};
      end
    end
  end

  assign ph0   = hit_q[0] & run;
  assign ph90  = hit_q[1] & run;
  assign ph180 = hit_q[2] & run;
  assign ph270 = hit_q[3] & run;

  a_phase_onehot: assert property (
    @(posedge sys_clk) disable iff (!arst_n)
    $onehot0({ph0, ph90, ph180, ph270})
  );

endmodule

`default_nettype wire

/* design/rst_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module rst_sequencer (
  input  logic sys_clk,
  input  logic arst_n,
  input  logic locked,
  input  logic idelay_rst,
  output logic por_active,
  output logic idelay_rdy
);

  typedef enum logic [1:0] {
    WAIT_LOCK,
    POR_HOLD_ST,
    CALIB,
    READY
  } seq_state_e;

  seq_state_e            state;
  clk_cfg_pkg::seq_cnt_t cnt;  // Shared by POR hold and calibration

  always_ff @(posedge sys_clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= WAIT_LOCK;
      cnt   <= '0;
    end else if (!locked) begin
      state <= WAIT_LOCK;
    end else begin
      case (state)
        WAIT_LOCK: begin
          // One hold cycle spent here and one on exit
          state <= POR_HOLD_ST;
          cnt   <= clk_cfg_pkg::seq_cnt_t'(clk_cfg_pkg::POR_HOLD - 2);
        end
        POR_HOLD_ST: begin
          if (cnt == '0) begin
            state <= CALIB;
            cnt   <= clk_cfg_pkg::seq_cnt_t'(clk_cfg_pkg::IDELAY_CYCLES - 1);
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        CALIB: begin
          if (idelay_rst) begin
            cnt <= clk_cfg_pkg::seq_cnt_t'(clk_cfg_pkg::IDELAY_CYCLES - 1);
          end else if (cnt == '0) begin
            state <= READY;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        READY: begin
          if (idelay_rst) begin
            state <= CALIB;  // Recalibrate
            cnt   <= clk_cfg_pkg::seq_cnt_t'(clk_cfg_pkg::IDELAY_CYCLES - 1);
          end
        end
        default: state <= WAIT_LOCK;
      endcase
    end
  end

  // Lock loss asserts POR in the same cycle
  assign por_active = (state == WAIT_LOCK) || (state == POR_HOLD_ST) || !locked;
  assign idelay_rdy = (state == READY) && locked && !idelay_rst;

  // Ready only after a full calibration time clear of POR and idelay_rst
  a_rdy_after_por: assert property (
    @(posedge sys_clk) disable iff (!arst_n)
    $rose(idelay_rdy) |-> $past(!por_active && !idelay_rst, clk_cfg_pkg::IDELAY_CYCLES)
  );

endmodule

`default_nettype wire

/* design/lock_monitor.sv */
`timescale 1ns/1ns
`default_nettype none

module lock_monitor (
  input  logic                  sys_clk,
  input  logic                  arst_n,
  input  clk_cfg_pkg::div_sel_e div_sel,
  output logic                  locked,
  output logic [7:0]            relock_cnt
);

  clk_cfg_pkg::div_sel_e  last_div;
  clk_cfg_pkg::lock_cnt_t settle_cnt;
  logic                   reconfig;

  assign reconfig = (div_sel != last_div);

  // Behavioral stand-in for the MMCM LOCKED output
  always_ff @(posedge sys_clk or negedge arst_n) begin
    if (!arst_n) begin
      last_div   <= clk_cfg_pkg::DIV8;
      settle_cnt <= clk_cfg_pkg::lock_cnt_t'(clk_cfg_pkg::LOCK_CYCLES);
      locked     <= 1'b0;
      relock_cnt <= '0;
    end else begin
      last_div <= div_sel;
      if (reconfig) begin
        locked     <= 1'b0;  // Reprogramming loses lock
        settle_cnt <= clk_cfg_pkg::lock_cnt_t'(clk_cfg_pkg::LOCK_CYCLES);
      end else if (settle_cnt != '0) begin
        settle_cnt <= settle_cnt - 1'b1;
        if (settle_cnt == clk_cfg_pkg::lock_cnt_t'(1)) begin
          locked     <= 1'b1;
          relock_cnt <= relock_cnt + 8'd1;
        end
      end
    end
  end

  a_lock_settled: assert property (
    @(posedge sys_clk) disable iff (!arst_n)
    $rose(locked) |-> (settle_cnt == '0)
  );

endmodule

`default_nettype wire

/* design/clk_infra_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module clk_infra_regs (
  input  logic                   sys_clk,
  input  logic                   arst_n,
  input  wb_pkg::wb_req_t        wb_req,
  output wb_pkg::wb_rsp_t        wb_rsp,
  input  clk_cfg_pkg::clk_status_t status,
  output clk_cfg_pkg::div_sel_e  div_sel,
  output logic                   phase_en
);

  logic                        ack_q;
  logic                        served_q;  // Set once this strobe has been acked
  logic                        req_valid;
  logic                        fire;
  logic [wb_pkg::WB_DAT_W-1:0] rd_mux;
  logic [wb_pkg::WB_DAT_W-1:0] rdat_q;
  wb_pkg::reg_addr_e           addr;

  assign req_valid = wb_req.cyc & wb_req.stb;
  assign fire      = req_valid & ~ack_q & ~served_q;
  assign addr      = wb_pkg::reg_addr_e'(wb_req.adr);

  // Read data select
  always_comb begin
    rd_mux = '0;
    case (addr)
      wb_pkg::REG_CTRL: begin
        rd_mux[wb_pkg::CTRL_DIV_LSB +: 2]     = div_sel;
        rd_mux[wb_pkg::CTRL_PHASE_EN_BIT]     = phase_en;
      end
      wb_pkg::REG_STATUS: begin
        rd_mux[0] = status.locked;
        rd_mux[1] = status.por_active;
        rd_mux[2] = status.idelay_rdy;
      end
      wb_pkg::REG_RELOCK: rd_mux[7:0] = status.relock_cnt;
      default:            rd_mux = '0;  // Unused addresses read zero
    endcase
  end

  // One wait state, single ack per strobe
  always_ff @(posedge sys_clk or negedge arst_n) begin
    if (!arst_n) begin
      ack_q    <= 1'b0;
      served_q <= 1'b0;
    end else begin
      ack_q <= fire;
      if (!req_valid) begin
        served_q <= 1'b0;
      end else if (ack_q) begin
        served_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (fire) begin
      rdat_q <= rd_mux;
    end
  end

  // CTRL is the only writable register
  always_ff @(posedge sys_clk or negedge arst_n) begin
    if (!arst_n) begin
      div_sel  <= clk_cfg_pkg::DIV8;
      phase_en <= 1'b1;
    end else if (fire && wb_req.we && addr == wb_pkg::REG_CTRL) begin
      div_sel  <= clk_cfg_pkg::div_sel_e'(wb_req.dat[wb_pkg::CTRL_DIV_LSB +: 2]);
      phase_en <= wb_req.dat[wb_pkg::CTRL_PHASE_EN_BIT];
    end
  end

  assign wb_rsp = '{ack: ack_q, dat: rdat_q};

  // Ack is a single-cycle pulse
  a_ack_single: assert property (
    @(posedge sys_clk) disable iff (!arst_n)
    wb_rsp.ack |=> !wb_rsp.ack
  );

endmodule

`default_nettype wire

/* design/wb_pkg.sv */
`default_nettype none

package wb_pkg;

  localparam int WB_ADR_W = 4;
  localparam int WB_DAT_W = 32;

  // CTRL register fields
  localparam int CTRL_DIV_LSB      = 0;
  localparam int CTRL_PHASE_EN_BIT = 2;

  typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;
    logic [WB_ADR_W-1:0] adr;
    logic [WB_DAT_W-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic                ack;
    logic [WB_DAT_W-1:0] dat;
  } wb_rsp_t;

  // Register map
  typedef enum logic [WB_ADR_W-1:0] {
    REG_CTRL   = 4'd0,  // RW, div_sel and phase_en
    REG_STATUS = 4'd1,  // RO, locked / por_active / idelay_rdy
    REG_RELOCK = 4'd2   // RO, relock count
  } reg_addr_e;

endpackage

`default_nettype wire

/* design/clk_cfg_pkg.sv */
`default_nettype none

package clk_cfg_pkg;

  // Phase period select, P = 4 << div_sel
  typedef enum logic [1:0] {
    DIV4  = 2'd0,
    DIV8  = 2'd1,
    DIV16 = 2'd2,
    DIV32 = 2'd3
  } div_sel_e;

  localparam int LOCK_CYCLES   = 32;  // Lock drop to lock rise
  localparam int POR_HOLD      = 16;  // POR held after lock rises
  localparam int IDELAY_CYCLES = 12;  // Calibration time

  localparam int LOCK_CNT_W = $clog2(LOCK_CYCLES + 1);
  localparam int SEQ_CNT_W  = $clog2((POR_HOLD > IDELAY_CYCLES) ? POR_HOLD : IDELAY_CYCLES);

  typedef logic [LOCK_CNT_W-1:0] lock_cnt_t;
  typedef logic [SEQ_CNT_W-1:0]  seq_cnt_t;

  typedef struct packed {
    logic       locked;
    logic       por_active;
    logic       idelay_rdy;
    logic [7:0] relock_cnt;
  } clk_status_t;

  // Period in sys_clk cycles
  function automatic logic [5:0] div_period(div_sel_e sel);
    case (sel)
      DIV4:    return 6'd4;
      DIV8:    return 6'd8;
      DIV16:   return 6'd16;
      default: return 6'd32;
    endcase
  endfunction

endpackage

`default_nettype wire
